//--- design/core_pkg.sv
//////////////////////////////
// Shared opcodes, instruction layout and register constants
// for the ALU core, used by scoped name
//////////////////////////////

package core_pkg;

	// An instruction word is always 32 bits wide
	localparam int INSTR_WIDTH = 32;

	// The register file has 16 entries, so a register number takes 4 bits
	localparam int REG_COUNT = 16;
	localparam int REG_ADDR_WIDTH = $clog2(REG_COUNT);

	// The immediate is zero-extended to the data width by the execute stage
	localparam int IMM_WIDTH = 16;

	// Opcode field, the top nibble of the word
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 28;

	// Destination register field
	localparam int DEST_MSB = 27;
	localparam int DEST_LSB = 24;

	// First source register field, goes to SRAM read port 1
	localparam int SRC_A_MSB = 23;
	localparam int SRC_A_LSB = 20;

	// Second source register field, goes to SRAM read port 2
	localparam int SRC_B_MSB = 19;
	localparam int SRC_B_LSB = 16;

	// The immediate fills the low half of the word
	localparam int IMM_LSB = 0;
	localparam int IMM_MSB = IMM_LSB + IMM_WIDTH - 1;

	typedef logic [REG_ADDR_WIDTH - 1:0] reg_addr_t;

	// Only the lower eight codes of the 4-bit field are defined
	typedef enum logic [OPCODE_MSB - OPCODE_LSB:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SHL = 4'd5,
		OP_SHR = 4'd6,
		OP_LDI = 4'd7
	} opcode_t;

endpackage

//--- design/decode_if.sv
//////////////////////////////
// Decoded instruction passed from decode to execute
//////////////////////////////

interface decode_if #(
	parameter int DATA_WIDTH = 32
);

	// One-cycle strobe, high for each decoded instruction
	logic valid;

	// Operation and register numbers taken straight from the instruction word
	core_pkg::opcode_t op;
	core_pkg::reg_addr_t dest;
	core_pkg::reg_addr_t src_a;
	core_pkg::reg_addr_t src_b;

	// Raw immediate, widened to DATA_WIDTH in execute
	logic [core_pkg::IMM_WIDTH - 1:0] imm;

	// The immediate must fit into a data word without losing bits
	initial
	begin
		assert (DATA_WIDTH >= core_pkg::IMM_WIDTH)
		else $fatal(1, "decode_if: DATA_WIDTH %0d narrower than immediate", DATA_WIDTH);
	end

	// Decode registers the fields into the interface
	modport producer (
		output valid,
		output op,
		output dest,
		output src_a,
		output src_b,
		output imm
	);

	// Execute only reads the fields
	modport consumer (
		input valid,
		input op,
		input dest,
		input src_a,
		input src_b,
		input imm
	);

endinterface

//--- design/sram_2r1w.sv
//////////////////////////////
// Two-read one-write synchronous SRAM with write bypass
//////////////////////////////

module sram_2r1w #(
	parameter int DATA_WIDTH = 32,
	parameter int SIZE = 1024,
	parameter int ADDR_WIDTH = $clog2(SIZE)
) (
	input  logic                    clk,
	input  logic                    read1_en,
	input  logic [ADDR_WIDTH - 1:0] read1_addr,
	output logic [DATA_WIDTH - 1:0] read1_data,
	input  logic                    read2_en,
	input  logic [ADDR_WIDTH - 1:0] read2_addr,
	output logic [DATA_WIDTH - 1:0] read2_data,
	input  logic                    write_en,
	input  logic [ADDR_WIDTH - 1:0] write_addr,
	input  logic [DATA_WIDTH - 1:0] write_data
);

	// Storage array, contents survive reset
	logic [DATA_WIDTH - 1:0] mem [SIZE];

	// A read hits the write port when both target the same word this cycle
	logic read1_hit;
	logic read2_hit;

	assign read1_hit = write_en && (write_addr == read1_addr);
	assign read2_hit = write_en && (write_addr == read2_addr);

	// Single write port
	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;
	end

	// Read port 1 returns the word one edge after the address
	// On a hit the incoming write data is returned instead of the stale word
	always_ff @(posedge clk)
	begin
		if (read1_en)
		begin
			if (read1_hit)
				read1_data <= write_data;
			else
				read1_data <= mem[read1_addr];
		end
	end

	// Read port 2 behaves the same way; with enable low both ports hold
	always_ff @(posedge clk)
	begin
		if (read2_en)
		begin
			if (read2_hit)
				read2_data <= write_data;
			else
				read2_data <= mem[read2_addr];
		end
	end

endmodule

//--- design/instr_decode.sv
//////////////////////////////
// Decode stage, splits the instruction and starts both
// register file reads in the same cycle
//////////////////////////////

module instr_decode #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                instr_valid,
	input  logic [core_pkg::INSTR_WIDTH - 1:0]  instr,
	output logic                                read1_en,
	output core_pkg::reg_addr_t                 read1_addr,
	output logic                                read2_en,
	output core_pkg::reg_addr_t                 read2_addr,
	decode_if.producer                          dec
);

	// Raw instruction fields
	logic [core_pkg::OPCODE_MSB - core_pkg::OPCODE_LSB:0] op_raw;
	core_pkg::reg_addr_t dest_field;
	core_pkg::reg_addr_t src_a_field;
	core_pkg::reg_addr_t src_b_field;
	logic [core_pkg::IMM_WIDTH - 1:0] imm_field;
	logic reads_regs;

	assign op_raw      = instr[core_pkg::OPCODE_MSB:core_pkg::OPCODE_LSB];
	assign dest_field  = instr[core_pkg::DEST_MSB:core_pkg::DEST_LSB];
	assign src_a_field = instr[core_pkg::SRC_A_MSB:core_pkg::SRC_A_LSB];
	assign src_b_field = instr[core_pkg::SRC_B_MSB:core_pkg::SRC_B_LSB];
	assign imm_field   = instr[core_pkg::IMM_MSB:core_pkg::IMM_LSB];

	// Load-immediate needs no source registers, so its reads stay off
	// and the SRAM outputs keep their last value
	assign reads_regs = instr_valid && (op_raw != core_pkg::OP_LDI);

	// Read addresses come straight off the incoming word so that the data
	// lines up with the registered fields one cycle later
	assign read1_en   = reads_regs;
	assign read1_addr = src_a_field;
	assign read2_en   = reads_regs;
	assign read2_addr = src_b_field;

	// Valid strobe is the only control state in this stage
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			dec.valid <= 1'b0;
		else
			dec.valid <= instr_valid;
	end

	// Fields are only loaded for a real instruction
	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			dec.op    <= core_pkg::opcode_t'(op_raw);
			dec.dest  <= dest_field;
			dec.src_a <= src_a_field;
			dec.src_b <= src_b_field;
			dec.imm   <= imm_field;
		end
	end

	// Execute widens the immediate into a data word
	initial
	begin
		assert (DATA_WIDTH >= core_pkg::IMM_WIDTH)
		else $fatal(1, "instr_decode: DATA_WIDTH %0d too small", DATA_WIDTH);
	end

	// Codes 8 to 15 are undefined and must never reach the pipeline
	a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> op_raw inside {core_pkg::OP_ADD, core_pkg::OP_SUB,
			core_pkg::OP_AND, core_pkg::OP_OR, core_pkg::OP_XOR,
			core_pkg::OP_SHL, core_pkg::OP_SHR, core_pkg::OP_LDI})
		else $error("instr_decode: undefined opcode %0h accepted", op_raw);

endmodule

//--- design/alu_execute.sv
//////////////////////////////
// Execute stage, forwards its own last result and
// registers one ALU result per cycle
//////////////////////////////

module alu_execute #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [DATA_WIDTH - 1:0] read1_data,
	input  logic [DATA_WIDTH - 1:0] read2_data,
	decode_if.consumer              dec,
	output logic                    ex_valid,
	output core_pkg::reg_addr_t     ex_dest,
	output logic [DATA_WIDTH - 1:0] ex_data
);

	// Shift amounts use only the low five bits of operand B
	localparam int SHAMT_WIDTH = 5;

	logic fwd_a;
	logic fwd_b;
	logic [DATA_WIDTH - 1:0] operand_a;
	logic [DATA_WIDTH - 1:0] operand_b;
	logic [SHAMT_WIDTH - 1:0] shamt;
	logic [DATA_WIDTH - 1:0] imm_ext;
	logic [DATA_WIDTH - 1:0] result;

	// The SRAM has not seen the result registered last edge yet, since
	// writeback only writes it this cycle, so a directly following
	// dependent instruction takes the operand from ex_data
	assign fwd_a = ex_valid && (ex_dest == dec.src_a);
	assign fwd_b = ex_valid && (ex_dest == dec.src_b);

	assign operand_a = fwd_a ? ex_data : read1_data;
	assign operand_b = fwd_b ? ex_data : read2_data;

	assign shamt = operand_b[SHAMT_WIDTH - 1:0];

	// Immediate is unsigned, upper bits are zero
	assign imm_ext = DATA_WIDTH'(dec.imm);

	// Add and subtract simply drop the carry, which gives the wraparound
	always_comb
	begin
		case (dec.op)
			core_pkg::OP_ADD:
				result = operand_a + operand_b;
			core_pkg::OP_SUB:
				result = operand_a - operand_b;
			core_pkg::OP_AND:
				result = operand_a & operand_b;
			core_pkg::OP_OR:
				result = operand_a | operand_b;
			core_pkg::OP_XOR:
				result = operand_a ^ operand_b;
			core_pkg::OP_SHL:
				result = operand_a << shamt;
			core_pkg::OP_SHR:
				result = operand_a >> shamt;
			core_pkg::OP_LDI:
				result = imm_ext;
			default:
				result = '0;
		endcase
	end

	// Valid bit follows the decode strobe
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec.valid;
	end

	// Result and destination only change for a real instruction
	always_ff @(posedge clk)
	begin
		if (dec.valid)
		begin
			ex_dest <= dec.dest;
			ex_data <= result;
		end
	end

	// An X here would corrupt both forwarding and the register file write
	a_ex_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(ex_valid))
		else $error("alu_execute: ex_valid unknown");

endmodule

//--- design/result_writeback.sv
//////////////////////////////
// Result stage, writes the register file and drives
// the registered result ports
//////////////////////////////

module result_writeback #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ex_valid,
	input  core_pkg::reg_addr_t     ex_dest,
	input  logic [DATA_WIDTH - 1:0] ex_data,
	output logic                    write_en,
	output core_pkg::reg_addr_t     write_addr,
	output logic [DATA_WIDTH - 1:0] write_data,
	output logic                    result_valid,
	output core_pkg::reg_addr_t     result_dest,
	output logic [DATA_WIDTH - 1:0] result_data,
	output logic                    result_zero
);

	logic data_is_zero;

	// The write happens during the same cycle that ex_valid is high, so
	// the value is stored at the next edge and reads at that edge bypass
	assign write_en   = ex_valid;
	assign write_addr = ex_dest;
	assign write_data = ex_data;

	assign data_is_zero = (ex_data == '0);

	// Control outputs, cleared on reset
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			result_valid <= 1'b0;
			result_zero  <= 1'b0;
		end
		else
		begin
			result_valid <= ex_valid;
			// Zero flag is only raised for a real result
			result_zero  <= ex_valid && data_is_zero;
		end
	end

	// Payload keeps the last result between instructions
	always_ff @(posedge clk)
	begin
		if (ex_valid)
		begin
			result_dest <= ex_dest;
			result_data <= ex_data;
		end
	end

	// The address comes from execute's destination register, which must
	// have been loaded by an earlier decode strobe
	a_write_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		write_en |-> !$isunknown(write_addr))
		else $error("result_writeback: write with unknown address");

endmodule

//--- design/alu_core.sv
//////////////////////////////
// Top level of the ALU core, three stages around the
// register file SRAM
//////////////////////////////

module alu_core #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               instr_valid,
	input  logic [core_pkg::INSTR_WIDTH - 1:0] instr,
	output logic                               result_valid,
	output core_pkg::reg_addr_t                result_dest,
	output logic [DATA_WIDTH - 1:0]            result_data,
	output logic                               result_zero
);

	// SRAM read side, driven by decode and consumed by execute
	logic read1_en;
	core_pkg::reg_addr_t read1_addr;
	logic [DATA_WIDTH - 1:0] read1_data;
	logic read2_en;
	core_pkg::reg_addr_t read2_addr;
	logic [DATA_WIDTH - 1:0] read2_data;

	// Execute to writeback
	logic ex_valid;
	core_pkg::reg_addr_t ex_dest;
	logic [DATA_WIDTH - 1:0] ex_data;

	// SRAM write side, driven by writeback
	logic write_en;
	core_pkg::reg_addr_t write_addr;
	logic [DATA_WIDTH - 1:0] write_data;

	decode_if #(.DATA_WIDTH(DATA_WIDTH)) dec ();

	instr_decode #(.DATA_WIDTH(DATA_WIDTH)) i_instr_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.read1_en    (read1_en),
		.read1_addr  (read1_addr),
		.read2_en    (read2_en),
		.read2_addr  (read2_addr),
		.dec         (dec.producer)
	);

	// One word per register, the address width follows from SIZE
	sram_2r1w #(
		.DATA_WIDTH (DATA_WIDTH),
		.SIZE       (core_pkg::REG_COUNT)
	) i_reg_file (
		.clk        (clk),
		.read1_en   (read1_en),
		.read1_addr (read1_addr),
		.read1_data (read1_data),
		.read2_en   (read2_en),
		.read2_addr (read2_addr),
		.read2_data (read2_data),
		.write_en   (write_en),
		.write_addr (write_addr),
		.write_data (write_data)
	);

	alu_execute #(.DATA_WIDTH(DATA_WIDTH)) i_alu_execute (
		.clk        (clk),
		.rst_n      (rst_n),
		.read1_data (read1_data),
		.read2_data (read2_data),
		.dec        (dec.consumer),
		.ex_valid   (ex_valid),
		.ex_dest    (ex_dest),
		.ex_data    (ex_data)
	);

	result_writeback #(.DATA_WIDTH(DATA_WIDTH)) i_result_writeback (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_valid     (ex_valid),
		.ex_dest      (ex_dest),
		.ex_data      (ex_data),
		.write_en     (write_en),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.result_valid (result_valid),
		.result_dest  (result_dest),
		.result_data  (result_data),
		.result_zero  (result_zero)
	);

endmodule

//--- tb/clock_gen.sv
//////////////////////////////
// Testbench clock and reset, 4 ns period
//////////////////////////////

module clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// Free running clock, first rising edge at 2 ns
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Reset is synchronous, so it is held low over two rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (2)
			@(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- tb/alu_core_tb.sv
//////////////////////////////
// Testbench for the ALU core that applies a stimulus table
// and checks every result against a register model
//////////////////////////////

module alu_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_WIDTH = 32;
	// Cycles from instr_valid to result_valid
	localparam int LATENCY = 3;
	localparam int TABLE_LEN = 51;
	localparam int CYCLE_LIMIT = TABLE_LEN + 20;

	typedef logic [DATA_WIDTH - 1:0] data_t;

	// One table row per instruction
	// A gap row holds instr_valid low for a cycle
	typedef struct packed {
		core_pkg::opcode_t op;
		core_pkg::reg_addr_t dest;
		core_pkg::reg_addr_t src_a;
		core_pkg::reg_addr_t src_b;
		logic [core_pkg::IMM_WIDTH - 1:0] imm;
		logic gap;
	} stim_t;

	logic clk;
	logic rst_n;
	logic instr_valid;
	logic [core_pkg::INSTR_WIDTH - 1:0] instr;
	logic result_valid;
	core_pkg::reg_addr_t result_dest;
	data_t result_data;
	logic result_zero;

	stim_t stim_table [TABLE_LEN];
	int fill_idx = 0;

	// Register model that is updated in issue order
	data_t reg_model [core_pkg::REG_COUNT];

	// Results still in flight with the oldest first
	core_pkg::reg_addr_t exp_dest_q [$];
	data_t exp_data_q [$];
	int exp_edge_q [$];

	int edge_count = 0;
	int error_count = 0;
	int checked_count = 0;
	integer seed = 32'h0742_cd5a;

	clock_gen i_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	alu_core #(.DATA_WIDTH(DATA_WIDTH)) i_alu_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.result_valid (result_valid),
		.result_dest  (result_dest),
		.result_data  (result_data),
		.result_zero  (result_zero)
	);

	always @(posedge clk)
		edge_count <= edge_count + 1;

	task automatic store_entry(input stim_t e);
		if (fill_idx < TABLE_LEN)
			stim_table[fill_idx] = e;
		else
		begin
			$display("Stimulus table overflow at entry %0d", fill_idx);
			error_count++;
		end
		fill_idx++;
	endtask

	task automatic ldi_entry(input core_pkg::reg_addr_t dest, input logic [15:0] imm);
		stim_t e;
		e = '0;
		e.op = core_pkg::OP_LDI;
		e.dest = dest;
		e.imm = imm;
		store_entry(e);
	endtask

	task automatic alu_entry(
		input core_pkg::opcode_t op,
		input core_pkg::reg_addr_t dest,
		input core_pkg::reg_addr_t src_a,
		input core_pkg::reg_addr_t src_b
	);
		stim_t e;
		e = '0;
		e.op = op;
		e.dest = dest;
		e.src_a = src_a;
		e.src_b = src_b;
		store_entry(e);
	endtask

	task automatic gap_entry();
		stim_t e;
		e = '0;
		e.gap = 1'b1;
		store_entry(e);
	endtask

	task automatic build_table();
		logic [31:0] rand_word;
		// r0 loads zero so an LDI raises the zero flag
		ldi_entry(4'd0, 16'h0000);
		for (int r = 1; r < 14; r++)
		begin
			rand_word = $random(seed);
			ldi_entry(core_pkg::reg_addr_t'(r), rand_word[15:0]);
		end
		// r14 holds a small shift amount and r15 one above 15
		rand_word = $random(seed);
		ldi_entry(4'd14, (rand_word[15:0] & 16'hffe0) | 16'h0003);
		rand_word = $random(seed);
		ldi_entry(4'd15, (rand_word[15:0] & 16'hffe0) | 16'h0014);
		// Every operation once on random values
		alu_entry(core_pkg::OP_ADD, 4'd1, 4'd2, 4'd3);
		alu_entry(core_pkg::OP_SUB, 4'd4, 4'd5, 4'd6);
		alu_entry(core_pkg::OP_SUB, 4'd7, 4'd0, 4'd8);
		alu_entry(core_pkg::OP_AND, 4'd9, 4'd10, 4'd11);
		alu_entry(core_pkg::OP_OR, 4'd12, 4'd13, 4'd2);
		alu_entry(core_pkg::OP_XOR, 4'd3, 4'd5, 4'd6);
		alu_entry(core_pkg::OP_SHL, 4'd8, 4'd10, 4'd15);
		alu_entry(core_pkg::OP_SHR, 4'd10, 4'd8, 4'd14);
		alu_entry(core_pkg::OP_SHR, 4'd11, 4'd12, 4'd15);
		alu_entry(core_pkg::OP_SHL, 4'd13, 4'd9, 4'd14);
		// r7 is close to the top of the range after 0 - r8, so this wraps
		alu_entry(core_pkg::OP_ADD, 4'd6, 4'd7, 4'd7);
		// Chain where each uses the previous destination twice
		alu_entry(core_pkg::OP_ADD, 4'd1, 4'd6, 4'd6);
		alu_entry(core_pkg::OP_SHR, 4'd2, 4'd1, 4'd1);
		alu_entry(core_pkg::OP_ADD, 4'd3, 4'd2, 4'd2);
		alu_entry(core_pkg::OP_SHL, 4'd4, 4'd3, 4'd3);
		alu_entry(core_pkg::OP_AND, 4'd5, 4'd4, 4'd4);
		alu_entry(core_pkg::OP_XOR, 4'd6, 4'd5, 4'd5);
		// Dependencies two apart go through the SRAM bypass
		alu_entry(core_pkg::OP_ADD, 4'd7, 4'd9, 4'd11);
		alu_entry(core_pkg::OP_OR, 4'd8, 4'd12, 4'd13);
		alu_entry(core_pkg::OP_SUB, 4'd9, 4'd7, 4'd12);
		alu_entry(core_pkg::OP_XOR, 4'd10, 4'd8, 4'd8);
		alu_entry(core_pkg::OP_AND, 4'd11, 4'd9, 4'd9);
		// Gaps push dependencies onto the bypass and then onto stored values
		gap_entry();
		alu_entry(core_pkg::OP_ADD, 4'd12, 4'd11, 4'd7);
		gap_entry();
		gap_entry();
		alu_entry(core_pkg::OP_SHL, 4'd13, 4'd12, 4'd14);
		gap_entry();
		alu_entry(core_pkg::OP_SUB, 4'd14, 4'd13, 4'd1);
		alu_entry(core_pkg::OP_XOR, 4'd15, 4'd15, 4'd15);
		alu_entry(core_pkg::OP_OR, 4'd0, 4'd15, 4'd14);
		rand_word = $random(seed);
		ldi_entry(4'd1, rand_word[15:0]);
		alu_entry(core_pkg::OP_ADD, 4'd2, 4'd1, 4'd0);
		gap_entry();
		// r15 is zero here, so this shifts by nothing
		alu_entry(core_pkg::OP_SHR, 4'd3, 4'd2, 4'd15);
		if (fill_idx != TABLE_LEN)
		begin
			$display("Stimulus table holds %0d entries, %0d expected", fill_idx, TABLE_LEN);
			error_count++;
		end
	endtask

	// Packs a table row into the 32-bit instruction layout
	function automatic logic [31:0] encode_instr(input stim_t e);
		logic [31:0] word;
		word = '0;
		word[core_pkg::OPCODE_MSB:core_pkg::OPCODE_LSB] = e.op;
		word[core_pkg::DEST_MSB:core_pkg::DEST_LSB] = e.dest;
		word[core_pkg::SRC_A_MSB:core_pkg::SRC_A_LSB] = e.src_a;
		word[core_pkg::SRC_B_MSB:core_pkg::SRC_B_LSB] = e.src_b;
		word[core_pkg::IMM_MSB:core_pkg::IMM_LSB] = e.imm;
		return word;
	endfunction

	// Expected result from the operation rules
	// Sums wrap at the data width
	function automatic data_t predict_result(
		input core_pkg::opcode_t op,
		input data_t a,
		input data_t b,
		input logic [15:0] imm
	);
		case (op)
			core_pkg::OP_ADD: return a + b;
			core_pkg::OP_SUB: return a - b;
			core_pkg::OP_AND: return a & b;
			core_pkg::OP_OR: return a | b;
			core_pkg::OP_XOR: return a ^ b;
			core_pkg::OP_SHL: return a << b[4:0];
			core_pkg::OP_SHR: return a >> b[4:0];
			default: return {{(DATA_WIDTH - core_pkg::IMM_WIDTH){1'b0}}, imm};
		endcase
	endfunction

	// Called on the edge that drives the instruction
	// At this point edge_count still holds the previous edge
	task automatic record_expected(input stim_t e);
		data_t value;
		value = predict_result(e.op, reg_model[e.src_a], reg_model[e.src_b], e.imm);
		reg_model[e.dest] = value;
		exp_dest_q.push_back(e.dest);
		exp_data_q.push_back(value);
		exp_edge_q.push_back(edge_count + 1 + LATENCY);
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t seen);
		if (seen !== expected)
		begin
			$display("ERROR at %0d ns: %s expected %h seen %h", $time, name, expected, seen);
			error_count++;
		end
	endtask

	task automatic check_dest(
		input string name,
		input core_pkg::reg_addr_t expected,
		input core_pkg::reg_addr_t seen
	);
		if (seen !== expected)
		begin
			$display("ERROR at %0d ns: %s expected %0d seen %0d", $time, name, expected, seen);
			error_count++;
		end
	endtask

	// Outputs are stable at the falling edge
	task automatic sample_outputs();
		core_pkg::reg_addr_t exp_dest;
		data_t exp_data;
		int exp_edge;
		logic exp_zero;
		if (result_valid === 1'b1)
		begin
			if (exp_data_q.size() == 0)
			begin
				$display("Unexpected result_valid at %0d ns with nothing outstanding", $time);
				error_count++;
			end
			else
			begin
				exp_dest = exp_dest_q.pop_front();
				exp_data = exp_data_q.pop_front();
				exp_edge = exp_edge_q.pop_front();
				checked_count++;
				if (exp_edge != edge_count)
				begin
					$display("Result for r%0d came at cycle %0d instead of cycle %0d",
						exp_dest, edge_count, exp_edge);
					error_count++;
				end
				check_dest("result_dest", exp_dest, result_dest);
				check_data("result_data", exp_data, result_data);
				exp_zero = (exp_data == '0);
				if (result_zero !== exp_zero)
				begin
					$display("ERROR at %0d ns: result_zero expected %b seen %b",
						$time, exp_zero, result_zero);
					error_count++;
				end
			end
		end
		else
		begin
			if (result_valid !== 1'b0)
			begin
				$display("ERROR at %0d ns: result_valid expected 0 seen %b", $time, result_valid);
				error_count++;
			end
			if (result_zero !== 1'b0)
			begin
				$display("ERROR at %0d ns: result_zero expected 0 seen %b", $time, result_zero);
				error_count++;
			end
			// The oldest result is overdue and counts as lost
			if (exp_edge_q.size() != 0 && exp_edge_q[0] <= edge_count)
			begin
				$display("Result for r%0d missing at cycle %0d", exp_dest_q[0], exp_edge_q[0]);
				error_count++;
				void'(exp_dest_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_edge_q.pop_front());
			end
		end
	endtask

	always @(negedge clk)
	begin
		if (rst_n === 1'b1)
			sample_outputs();
	end

	// Stops a hung run
	initial
	begin
		while (edge_count < CYCLE_LIMIT)
			@(posedge clk);
		$display("Timeout after %0d cycles, %0d results outstanding",
			edge_count, exp_edge_q.size());
		$display("Results checked: %0d, errors: %0d", checked_count, error_count);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		instr_valid = 1'b0;
		instr = '0;
		build_table();
		@(posedge clk);
		while (rst_n !== 1'b1)
			@(posedge clk);
		// Idle cycles let the monitor see both flags low before any instruction
		repeat (2)
			@(posedge clk);
		for (int idx = 0; idx < TABLE_LEN; idx++)
		begin
			if (stim_table[idx].gap)
			begin
				instr_valid <= 1'b0;
				instr <= '0;
			end
			else
			begin
				instr_valid <= 1'b1;
				instr <= encode_instr(stim_table[idx]);
				record_expected(stim_table[idx]);
			end
			@(posedge clk);
		end
		instr_valid <= 1'b0;
		instr <= '0;
		// The monitor runs on falling edges, so the end is judged on rising ones
		while (exp_edge_q.size() != 0)
			@(posedge clk);
		// A few more cycles catch any extra result_valid
		repeat (3)
			@(posedge clk);
		$display("Results checked: %0d, errors: %0d", checked_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- verilog.f
design/core_pkg.sv
design/decode_if.sv
design/sram_2r1w.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_writeback.sv
design/alu_core.sv
tb/clock_gen.sv
tb/alu_core_tb.sv

//--- run.sh
#!/bin/sh
# Builds the ALU core testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module alu_core_tb \
	-f verilog.f \
	-o alu_core_sim

./obj_dir/alu_core_sim | tee sim.log

if grep -q "Done: no errors" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
